// ==== logic/charge_arbiter.sv ====
// round robin charge arbiter
`timescale 1ns/1ns
`default_nettype none

module charge_arbiter (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    km_req,
  input  wire                    wait_req,
  output logic                   km_ack,
  output logic                   wait_ack,
  output logic                   fare_req,
  output taxi_pkg::charge_kind_t fare_kind,
  input  wire                    fare_ack
);

  typedef enum logic [1:0] {ARB_IDLE, ARB_GRANT, ARB_FARE, ARB_RELAY} arb_state_t;

  arb_state_t state;
  logic       prio_wait;  // wait meter wins a tie
  logic       pick_wait;
  logic       ack_r;
  logic       gnt_req;    // request of the granted meter

  assign pick_wait = wait_req && (!km_req || prio_wait);
  assign gnt_req   = (fare_kind == taxi_pkg::CHARGE_WAIT) ? wait_req : km_req;
  assign km_ack    = ack_r && (fare_kind == taxi_pkg::CHARGE_KM);
  assign wait_ack  = ack_r && (fare_kind == taxi_pkg::CHARGE_WAIT);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= ARB_IDLE;
      prio_wait <= 1'b0;
      fare_kind <= taxi_pkg::CHARGE_KM;
      fare_req  <= 1'b0;
      ack_r     <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: if (km_req || wait_req) begin
          fare_kind <= pick_wait ? taxi_pkg::CHARGE_WAIT : taxi_pkg::CHARGE_KM;
          prio_wait <= !pick_wait;  // other side next time
          state     <= ARB_GRANT;
        end
        ARB_GRANT: begin
          fare_req <= 1'b1;
          state    <= ARB_FARE;
        end
        ARB_FARE: if (fare_ack) begin
          fare_req <= 1'b0;
          ack_r    <= 1'b1;  // pass the ack back to the meter
          state    <= ARB_RELAY;
        end
        default: if (!gnt_req && !fare_ack) begin
          ack_r <= 1'b0;
          state <= ARB_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/distance_meter.sv ====
// distance meter
`timescale 1ns/1ns
`default_nettype none

module distance_meter (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                tick,
  input  wire                                waiting,
  input  wire                                ride_start,
  input  wire  [2:0]                         speed_sel,
  output logic                               req,
  input  wire                                ack,
  output logic [2*taxi_pkg::BCD_DIGIT_W-1:0] km_bcd
);

  localparam int D    = taxi_pkg::BCD_DIGIT_W;
  localparam int KM_W = 2 * D;
  localparam logic [KM_W-1:0] KM_MAX      = {2{D'(9)}};
  localparam logic [KM_W-1:0] FREE_KM_BCD = KM_W'(taxi_pkg::to_bcd(taxi_pkg::FREE_KM));

  logic [2:0]      spd_cnt;  // ticks into the current km
  logic [KM_W-1:0] km_next;
  logic            km_step;
  logic            earn;

  always_comb begin
    logic carry;
    carry = 1'b1;
    for (int i = 0; i < 2; i++) begin
      {carry, km_next[i*D +: D]} = taxi_pkg::bcd_digit_add(km_bcd[i*D +: D], '0, carry);
    end
  end

  assign km_step = tick && !waiting && (spd_cnt >= speed_sel);
  assign earn    = km_step && (km_bcd >= FREE_KM_BCD) && (km_bcd != KM_MAX);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      spd_cnt <= '0;
      km_bcd  <= '0;
    end else if (ride_start) begin
      spd_cnt <= '0;
      km_bcd  <= '0;
    end else if (tick && !waiting) begin
      if (km_step) begin
        spd_cnt <= '0;
        if (km_bcd != KM_MAX) km_bcd <= km_next;  // saturate at 99
      end else begin
        spd_cnt <= spd_cnt + 3'd1;
      end
    end
  end

  // four-phase request toward the arbiter
  always_ff @(posedge clk or posedge rst) begin
    if (rst)                      req <= 1'b0;
    else if (req && ack)          req <= 1'b0;
    else if (earn && !req && !ack) req <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== logic/fare_accumulator.sv ====
// fare accumulator in bcd jiao
`timescale 1ns/1ns
`default_nettype none

module fare_accumulator (
  input  wire                                          clk,
  input  wire                                          rst,
  input  wire                                          ride_start,
  input  wire                                          double_ride,
  input  wire                                          night,
  input  taxi_pkg::share_phase_t                       phase,
  input  wire                                          fare_req,
  input  taxi_pkg::charge_kind_t                       fare_kind,
  output logic                                         fare_ack,
  output logic [taxi_pkg::SHOW_DIGITS*taxi_pkg::BCD_DIGIT_W-1:0] fare1_yuan,
  output logic [taxi_pkg::SHOW_DIGITS*taxi_pkg::BCD_DIGIT_W-1:0] fare2_yuan
);

  localparam int D      = taxi_pkg::BCD_DIGIT_W;
  localparam int FARE_W = taxi_pkg::FARE_DIGITS * D;
  localparam int YUAN_W = taxi_pkg::SHOW_DIGITS * D;
  localparam logic [FARE_W-1:0] FARE_MAX_BCD = taxi_pkg::to_bcd(taxi_pkg::FARE_MAX);

  logic [FARE_W-1:0] fare1;  // first passenger
  logic [FARE_W-1:0] fare2;  // second passenger, or the only one
  logic [FARE_W-1:0] rate;
  logic [FARE_W-1:0] start_fare;
  logic              shared_rate;
  logic              p1_live;

  // bcd add with saturation at the top of the range
  function automatic logic [FARE_W-1:0] add_sat(
    input logic [FARE_W-1:0] fare,
    input logic [FARE_W-1:0] step
  );
    logic [FARE_W-1:0] sum;
    logic              carry;
    carry = 1'b0;
    for (int i = 0; i < taxi_pkg::FARE_DIGITS; i++) begin
      {carry, sum[i*D +: D]} = taxi_pkg::bcd_digit_add(fare[i*D +: D], step[i*D +: D], carry);
    end
    return carry ? FARE_MAX_BCD : sum;
  endfunction

  // half up on the jiao digit
  function automatic logic [YUAN_W-1:0] round_yuan(input logic [FARE_W-1:0] fare);
    logic [YUAN_W-1:0] up;
    logic              carry;
    carry = (fare[D-1:0] >= D'(5));
    for (int i = 0; i < taxi_pkg::SHOW_DIGITS; i++) begin
      {carry, up[i*D +: D]} = taxi_pkg::bcd_digit_add(fare[(i+1)*D +: D], '0, carry);
    end
    return carry ? {taxi_pkg::SHOW_DIGITS{D'(9)}} : up;
  endfunction

  assign shared_rate = double_ride && (phase == taxi_pkg::SHARED);
  assign p1_live     = !double_ride || (phase == taxi_pkg::SHARED);  // frozen after subtotal

  always_comb begin
    if (fare_kind == taxi_pkg::CHARGE_KM) begin
      case ({shared_rate, night})
        2'b00:   rate = taxi_pkg::to_bcd(taxi_pkg::RATE_KM_DAY);
        2'b01:   rate = taxi_pkg::to_bcd(taxi_pkg::RATE_KM_NIGHT);
        2'b10:   rate = taxi_pkg::to_bcd(taxi_pkg::RATE_KM_SHARE);
        default: rate = taxi_pkg::to_bcd(taxi_pkg::RATE_KM_SHARE_NIGHT);
      endcase
    end else begin
      case ({shared_rate, night})
        2'b00:   rate = taxi_pkg::to_bcd(taxi_pkg::RATE_WAIT_DAY);
        2'b01:   rate = taxi_pkg::to_bcd(taxi_pkg::RATE_WAIT_NIGHT);
        2'b10:   rate = taxi_pkg::to_bcd(taxi_pkg::RATE_WAIT_SHARE);
        default: rate = taxi_pkg::to_bcd(taxi_pkg::RATE_WAIT_SHARE_NIGHT);
      endcase
    end
  end

  always_comb begin
    case ({double_ride, night})
      2'b00:   start_fare = taxi_pkg::to_bcd(taxi_pkg::START_DAY);
      2'b01:   start_fare = taxi_pkg::to_bcd(taxi_pkg::START_NIGHT);
      2'b10:   start_fare = taxi_pkg::to_bcd(taxi_pkg::START_SHARE);
      default: start_fare = taxi_pkg::to_bcd(taxi_pkg::START_SHARE_NIGHT);
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fare_ack <= 1'b0;
      fare1    <= '0;
      fare2    <= '0;
    end else if (ride_start) begin
      fare1 <= start_fare;
      fare2 <= start_fare;
    end else if (fare_req && !fare_ack) begin
      fare2    <= add_sat(fare2, rate);
      if (p1_live) fare1 <= add_sat(fare1, rate);
      fare_ack <= 1'b1;
    end else if (!fare_req) begin
      fare_ack <= 1'b0;
    end
  end

  assign fare1_yuan = round_yuan(fare1);
  assign fare2_yuan = round_yuan(fare2);

endmodule

`default_nettype wire

// ==== logic/ride_control.sv ====
// ride control and tick generation
`timescale 1ns/1ns
`default_nettype none

module ride_control #(
  parameter int TICK_DIV = 50000
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    onride,
  input  wire                    wait_btn,
  input  wire                    stop_btn,
  input  wire                    subtotal_btn,
  input  wire                    double_ride,
  output logic                   tick,
  output logic                   waiting,
  output logic                   ride_start,
  output taxi_pkg::share_phase_t phase
);

  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  taxi_pkg::ride_state_t state;
  logic [CNT_W-1:0]      div_cnt;
  logic                  onride_q;  // edge detect
  logic                  metering;

  assign metering = (state == taxi_pkg::METER) || (state == taxi_pkg::WAIT);
  assign waiting  = (state == taxi_pkg::WAIT);
  assign tick     = metering && (div_cnt == CNT_W'(TICK_DIV - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= taxi_pkg::IDLE;
    end else if (!onride) begin
      state <= taxi_pkg::IDLE;
    end else begin
      case (state)
        taxi_pkg::IDLE:  state <= taxi_pkg::METER;
        taxi_pkg::METER: begin
          if (stop_btn)      state <= taxi_pkg::STOPPED;
          else if (wait_btn) state <= taxi_pkg::WAIT;
        end
        taxi_pkg::WAIT:  begin
          if (stop_btn)      state <= taxi_pkg::STOPPED;
          else if (wait_btn) state <= taxi_pkg::METER;  // back to driving
        end
        default: state <= taxi_pkg::STOPPED;  // frozen until onride drops
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      div_cnt <= '0;
    end else if (!metering || tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      onride_q   <= 1'b0;
      ride_start <= 1'b0;
      phase      <= taxi_pkg::SHARED;
    end else begin
      onride_q   <= onride;
      ride_start <= onride && !onride_q;
      if (!onride) phase <= taxi_pkg::SHARED;
      else if (subtotal_btn && double_ride && metering) phase <= taxi_pkg::SPLIT;  // sticky
    end
  end

endmodule

`default_nettype wire

// ==== logic/taxi_meter.sv ====
// taxi fare meter top
`timescale 1ns/1ns
`default_nettype none

module taxi_meter #(
  parameter int TICK_DIV = 50000
) (
  input  wire                                                   clk,
  input  wire                                                   rst,
  input  wire                                                   onride,
  input  wire                                                   double_ride,
  input  wire                                                   night,
  input  wire  [2:0]                                            speed_sel,
  input  wire                                                   wait_btn,
  input  wire                                                   stop_btn,
  input  wire                                                   subtotal_btn,
  output wire  [2*taxi_pkg::BCD_DIGIT_W-1:0]                    km_bcd,
  output wire  [3*taxi_pkg::BCD_DIGIT_W-1:0]                    wait_bcd,
  output wire  [taxi_pkg::SHOW_DIGITS*taxi_pkg::BCD_DIGIT_W-1:0] fare1_yuan,
  output wire  [taxi_pkg::SHOW_DIGITS*taxi_pkg::BCD_DIGIT_W-1:0] fare2_yuan
);

  wire                    tick;
  wire                    waiting;
  wire                    ride_start;
  taxi_pkg::share_phase_t phase;
  wire                    km_req;
  wire                    km_ack;
  wire                    wait_req;
  wire                    wait_ack;
  wire                    fare_req;
  wire                    fare_ack;
  taxi_pkg::charge_kind_t fare_kind;

  ride_control #(.TICK_DIV(TICK_DIV)) u_ride_control (
    .clk, .rst, .onride, .wait_btn, .stop_btn, .subtotal_btn, .double_ride,
    .tick, .waiting, .ride_start, .phase
  );

  // two meters share the fare register through the arbiter
  distance_meter u_distance_meter (
    .clk, .rst, .tick, .waiting, .ride_start, .speed_sel,
    .req(km_req), .ack(km_ack), .km_bcd
  );

  wait_meter u_wait_meter (
    .clk, .rst, .tick, .waiting, .ride_start,
    .req(wait_req), .ack(wait_ack), .wait_bcd
  );

  charge_arbiter u_charge_arbiter (
    .clk, .rst, .km_req, .wait_req, .km_ack, .wait_ack,
    .fare_req, .fare_kind, .fare_ack
  );

  fare_accumulator u_fare_accumulator (
    .clk, .rst, .ride_start, .double_ride, .night, .phase,
    .fare_req, .fare_kind, .fare_ack, .fare1_yuan, .fare2_yuan
  );

endmodule

`default_nettype wire

// ==== logic/taxi_pkg.sv ====
// taxi meter shared definitions
`default_nettype none

package taxi_pkg;

  typedef enum logic [1:0] {IDLE, METER, WAIT, STOPPED} ride_state_t;
  typedef enum logic {CHARGE_KM, CHARGE_WAIT} charge_kind_t;
  typedef enum logic {SHARED, SPLIT} share_phase_t;

  localparam int BCD_DIGIT_W = 4;
  localparam int FARE_DIGITS = 4;   // hundreds, tens, units of yuan, then jiao
  localparam int SHOW_DIGITS = 3;   // whole yuan on display

  localparam int unsigned FREE_KM     = 3;  // covered by the start fare
  localparam int unsigned FREE_WAIT_S = 5;
  localparam int unsigned WAIT_STEP_S = 3;

  // start fares, jiao
  localparam int unsigned START_DAY         = 130;
  localparam int unsigned START_NIGHT       = 166;
  localparam int unsigned START_SHARE       = 88;
  localparam int unsigned START_SHARE_NIGHT = 106;

  // per km, jiao
  localparam int unsigned RATE_KM_DAY         = 20;
  localparam int unsigned RATE_KM_NIGHT       = 24;
  localparam int unsigned RATE_KM_SHARE       = 12;
  localparam int unsigned RATE_KM_SHARE_NIGHT = 14;

  // per waiting charge, jiao
  localparam int unsigned RATE_WAIT_DAY         = 10;
  localparam int unsigned RATE_WAIT_NIGHT       = 12;
  localparam int unsigned RATE_WAIT_SHARE       = 6;
  localparam int unsigned RATE_WAIT_SHARE_NIGHT = 7;

  localparam int unsigned FARE_MAX = 9999;

  // one decimal digit add, result is {carry, digit}
  function automatic logic [BCD_DIGIT_W:0] bcd_digit_add(
    input logic [BCD_DIGIT_W-1:0] a,
    input logic [BCD_DIGIT_W-1:0] b,
    input logic                   cin
  );
    logic [BCD_DIGIT_W:0] sum;
    sum = {1'b0, a} + {1'b0, b} + {{BCD_DIGIT_W{1'b0}}, cin};
    if (sum > (BCD_DIGIT_W + 1)'(9)) sum = sum + (BCD_DIGIT_W + 1)'(6);  // decimal adjust
    return sum;
  endfunction

  // binary constant to packed bcd, fare width
  function automatic logic [FARE_DIGITS*BCD_DIGIT_W-1:0] to_bcd(input int unsigned value);
    logic [FARE_DIGITS*BCD_DIGIT_W-1:0] bcd;
    int unsigned rest;
    bcd  = '0;
    rest = value;
    for (int i = 0; i < FARE_DIGITS; i++) begin
      bcd[i*BCD_DIGIT_W +: BCD_DIGIT_W] = BCD_DIGIT_W'(rest % 10);
      rest = rest / 10;
    end
    return bcd;
  endfunction

endpackage

`default_nettype wire

// ==== logic/wait_meter.sv ====
// waiting time meter
`timescale 1ns/1ns
`default_nettype none

module wait_meter (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                tick,
  input  wire                                waiting,
  input  wire                                ride_start,
  output logic                               req,
  input  wire                                ack,
  output logic [3*taxi_pkg::BCD_DIGIT_W-1:0] wait_bcd
);

  localparam int D      = taxi_pkg::BCD_DIGIT_W;
  localparam int WAIT_W = 3 * D;
  localparam int STEP_W = 4;
  localparam logic [WAIT_W-1:0] WAIT_MAX = {3{D'(9)}};

  logic [WAIT_W-1:0] wait_next;
  logic [STEP_W-1:0] step;      // seconds since last charge point
  logic              charging;  // free period is over
  logic              sec_step;
  logic              earn;

  always_comb begin
    logic carry;
    carry = 1'b1;
    for (int i = 0; i < 3; i++) begin
      {carry, wait_next[i*D +: D]} = taxi_pkg::bcd_digit_add(wait_bcd[i*D +: D], '0, carry);
    end
  end

  assign sec_step = tick && waiting && (wait_bcd != WAIT_MAX);
  assign earn     = sec_step && (charging ? (step == STEP_W'(taxi_pkg::WAIT_STEP_S - 1))
                                          : (step == STEP_W'(taxi_pkg::FREE_WAIT_S - 1)));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wait_bcd <= '0;
      step     <= '0;
      charging <= 1'b0;
    end else if (ride_start) begin
      wait_bcd <= '0;
      step     <= '0;
      charging <= 1'b0;
    end else if (sec_step) begin
      wait_bcd <= wait_next;
      if (earn) begin
        step     <= '0;
        charging <= 1'b1;
      end else begin
        step <= step + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)                      req <= 1'b0;
    else if (req && ack)          req <= 1'b0;
    else if (earn && !req && !ack) req <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then look for the failure line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module taxi_meter_tb -f taxi_meter.f \
  -o taxi_meter_sim > build.log 2>&1 \
  && ./obj_dir/taxi_meter_sim > sim.log 2>&1 \
  || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && echo "simulation failed, see sim.log and build.log" && exit 1
echo "simulation passed"
exit 0

// ==== taxi_meter.f ====
+incdir+tb
logic/taxi_pkg.sv
logic/ride_control.sv
logic/distance_meter.sv
logic/wait_meter.sv
logic/charge_arbiter.sv
logic/fare_accumulator.sv
logic/taxi_meter.sv
tb/taxi_meter_assertions.sv
tb/taxi_meter_tb.sv

// ==== tb/taxi_meter_assertions.sv ====
// charge handshake assertions
`timescale 1ns/1ns
`default_nettype none

module charge_handshake_checks (
  input wire clk,
  input wire rst,
  input wire km_req,
  input wire wait_req,
  input wire km_ack,
  input wire wait_ack,
  input wire fare_req,
  input wire fare_ack
);

  logic [3:0] open_cycles;  // age of the current meter handshake

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      open_cycles <= '0;
    end else if (!(km_req || km_ack || wait_req || wait_ack)) begin
      open_cycles <= '0;
    end else if (open_cycles != 4'hf) begin
      open_cycles <= open_cycles + 1'b1;
    end
  end

  // requests stay up until acknowledged
  km_req_held: assert property (@(posedge clk) disable iff (rst)
    km_req && !km_ack |=> km_req) else $error("km req dropped before its ack");
  wait_req_held: assert property (@(posedge clk) disable iff (rst)
    wait_req && !wait_ack |=> wait_req) else $error("wait req dropped before its ack");
  fare_req_held: assert property (@(posedge clk) disable iff (rst)
    fare_req && !fare_ack |=> fare_req) else $error("fare req dropped before its ack");

  // an ack only ever answers a live request
  km_ack_answers: assert property (@(posedge clk) disable iff (rst)
    $rose(km_ack) |-> km_req) else $error("km ack rose with no km req");
  wait_ack_answers: assert property (@(posedge clk) disable iff (rst)
    $rose(wait_ack) |-> wait_req) else $error("wait ack rose with no wait req");
  fare_ack_answers: assert property (@(posedge clk) disable iff (rst)
    $rose(fare_ack) |-> fare_req) else $error("fare ack rose with no fare req");

  one_grant: assert property (@(posedge clk) disable iff (rst)
    !(km_ack && wait_ack)) else $error("both meters acknowledged at once");

  // a charge still open at the next one would stall the meter
  charge_closes: assert property (@(posedge clk) disable iff (rst)
    open_cycles <= 4'd8) else $error("charge handshake still open after 8 cycles");

endmodule

bind charge_arbiter charge_handshake_checks u_handshake_checks (
  .clk, .rst, .km_req, .wait_req, .km_ack, .wait_ack, .fare_req, .fare_ack
);

`default_nettype wire

// ==== tb/taxi_meter_tests.svh ====
// taxi meter directed tests
`ifndef TAXI_METER_TESTS_SVH
`define TAXI_METER_TESTS_SVH
`default_nettype none

task automatic check_outputs(input string name, input int km, input int secs,
                             input int f1_jiao, input int f2_jiao);
  check_value(name, "km", km, bcd_value({4'h0, km_bcd}));
  check_value(name, "wait", secs, bcd_value(wait_bcd));
  check_value(name, "fare1", shown_yuan(f1_jiao), bcd_value(fare1_yuan));
  check_value(name, "fare2", shown_yuan(f2_jiao), bcd_value(fare2_yuan));
endtask

// all four modes, day/night and single/shared
task automatic start_fare_test();
  for (int mode = 0; mode < 4; mode++) begin
    begin_ride(mode[1], mode[0], 3'd0);
    check_outputs("start_fare", 0, 0, start_jiao(mode[1], mode[0]), start_jiao(mode[1], mode[0]));
    end_ride();
  end
endtask

task automatic distance_test(input bit night_mode);
  int spd;
  int n;
  int fare;
  spd  = int'(take_bits(3));
  n    = 8 + int'(take_bits(5));
  fare = start_jiao(1'b0, night_mode) + km_charges(km_after(n, spd)) * km_rate(1'b0, night_mode);
  begin_ride(1'b0, night_mode, 3'(spd));
  run_ticks(n);
  check_outputs("distance", km_after(n, spd), 0, fare, fare);
  end_ride();
endtask

// drive 5 km first, waiting must leave km alone
task automatic wait_test();
  int secs;
  int fare;
  secs = 6 + int'(take_bits(4));
  fare = start_jiao(1'b0, 1'b1) + km_charges(5) * km_rate(1'b0, 1'b1)
         + wait_charges(secs) * wait_rate(1'b0, 1'b1);
  begin_ride(1'b0, 1'b1, 3'd0);
  run_ticks(5);
  press(BTN_WAIT);
  run_ticks(secs);
  check_outputs("waiting", 5, secs, fare, fare);
  end_ride();
endtask

task automatic shared_test();
  int more;
  int fare1;
  int fare2;
  more  = 4 + int'(take_bits(2));
  fare1 = start_jiao(1'b1, 1'b0) + km_charges(5) * km_rate(1'b1, 1'b0);
  fare2 = fare1 + (km_charges(5 + more) - km_charges(5)) * km_rate(1'b0, 1'b0);
  begin_ride(1'b1, 1'b0, 3'd0);
  run_ticks(5);
  check_outputs("shared", 5, 0, fare1, fare1);
  press(BTN_SUBTOTAL);
  run_ticks(more);  // second passenger at single rates
  check_outputs("split", 5 + more, 0, fare1, fare2);
  end_ride();
endtask

task automatic stop_test();
  int fare;
  fare = start_jiao(1'b0, 1'b1) + km_charges(km_after(10, 1)) * km_rate(1'b0, 1'b1);
  begin_ride(1'b0, 1'b1, 3'd1);
  run_ticks(10);
  press(BTN_STOP);
  repeat (5 * TICK_DIV) @(posedge clk);  // frozen, no ticks expected
  #1;
  check_outputs("stop", km_after(10, 1), 0, fare, fare);
  end_ride();
  begin_ride(1'b0, 1'b1, 3'd1);
  check_outputs("restart", 0, 0, start_jiao(1'b0, 1'b1), start_jiao(1'b0, 1'b1));
  end_ride();
endtask

`default_nettype wire
`endif

// ==== tb/taxi_meter_tb.sv ====
// taxi meter testbench
`timescale 1ns/1ns
`default_nettype none

module taxi_meter_tb;

  localparam int TICK_DIV     = 12;
  localparam int CLK_PERIOD   = 4;
  localparam int SETTLE       = 8;  // cycles for one full charge handshake
  localparam int BTN_WAIT     = 0;
  localparam int BTN_STOP     = 1;
  localparam int BTN_SUBTOTAL = 2;
  // cycle budget per test at the longest random draw
  localparam int START_CYCLES  = 4 * 8;
  localparam int DIST_CYCLES   = 2 * ((8 + 31 + 1) * TICK_DIV + 3 * SETTLE);
  localparam int WAIT_CYCLES   = (5 + 21 + 1) * TICK_DIV + 4 * SETTLE;
  localparam int SHARED_CYCLES = (5 + 7 + 1) * TICK_DIV + 4 * SETTLE;
  localparam int STOP_CYCLES   = (10 + 5 + 1) * TICK_DIV + 6 * SETTLE;
  localparam int WATCHDOG_NS   = 2 * CLK_PERIOD * (START_CYCLES + DIST_CYCLES + WAIT_CYCLES
                                 + SHARED_CYCLES + STOP_CYCLES + 100);

  logic        clk;
  logic        rst;
  logic        onride;
  logic        double_ride;
  logic        night;
  logic [2:0]  speed_sel;
  logic        wait_btn;
  logic        stop_btn;
  logic        subtotal_btn;
  wire  [7:0]  km_bcd;
  wire  [11:0] wait_bcd;
  wire  [11:0] fare1_yuan;
  wire  [11:0] fare2_yuan;
  logic [31:0] lfsr = 32'hc7b4_c623;
  int          err_count = 0;

  taxi_meter #(.TICK_DIV(TICK_DIV)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst          = 1'b1;
    onride       = 1'b0;
    double_ride  = 1'b0;
    night        = 1'b0;
    speed_sel    = 3'd0;
    wait_btn     = 1'b0;
    stop_btn     = 1'b0;
    subtotal_btn = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    start_fare_test();
    distance_test(1'b0);
    distance_test(1'b1);
    wait_test();
    shared_test();
    stop_test();
    if (err_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "%0d checks failed", err_count);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

  // galois lfsr, one step per bit
  function automatic int unsigned take_bits(input int n);
    int unsigned value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr  = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      value = (value << 1) | {31'b0, lfsr[0]};
    end
    return value;
  endfunction

  // fare rules in jiao
  function automatic int start_jiao(input bit share, input bit night_mode);
    if (share) return night_mode ? 106 : 88;
    return night_mode ? 166 : 130;
  endfunction

  function automatic int km_rate(input bit share, input bit night_mode);
    if (share) return night_mode ? 14 : 12;
    return night_mode ? 24 : 20;
  endfunction

  function automatic int wait_rate(input bit share, input bit night_mode);
    if (share) return night_mode ? 7 : 6;
    return night_mode ? 12 : 10;
  endfunction

  function automatic int km_after(input int ticks, input int spd);
    return (ticks / (spd + 1) > 99) ? 99 : ticks / (spd + 1);
  endfunction

  function automatic int km_charges(input int km);
    return (km > 3) ? km - 3 : 0;  // first 3 km are in the start fare
  endfunction

  function automatic int wait_charges(input int secs);
    return (secs < 5) ? 0 : 1 + (secs - 5) / 3;
  endfunction

  // whole yuan, half up
  function automatic int shown_yuan(input int jiao);
    int capped;
    capped = (jiao > 9999) ? 9999 : jiao;
    return ((capped + 5) / 10 > 999) ? 999 : (capped + 5) / 10;
  endfunction

  function automatic int bcd_value(input logic [11:0] bcd);
    int v;
    v = 0;
    for (int i = 2; i >= 0; i--) v = v * 10 + int'(bcd[i*4 +: 4]);
    return v;
  endfunction

  task automatic check_value(input string test_name, input string what,
                             input int expected, input int actual);
    assert (expected == actual) else begin
      err_count++;
      $display("mismatch in %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      $display("Something failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // counts metering ticks, then lets the last charge finish
  task automatic run_ticks(input int n);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < n) begin
      @(posedge clk);
      #1;
      cycles++;
      if (DUT.tick) seen++;
      if (cycles > (n + 1) * TICK_DIV) begin
        $display("metering tick missing, %0d of %0d ticks seen", seen, n);
        $display("Something failed");
        $fatal(1, "tick timeout");
      end
    end
    repeat (SETTLE) @(posedge clk);
    #1;
  endtask

  task automatic press(input int btn);
    wait_btn     = (btn == BTN_WAIT);
    stop_btn     = (btn == BTN_STOP);
    subtotal_btn = (btn == BTN_SUBTOTAL);
    @(posedge clk);
    #1;
    wait_btn     = 1'b0;
    stop_btn     = 1'b0;
    subtotal_btn = 1'b0;
  endtask

  task automatic begin_ride(input bit share, input bit night_mode, input logic [2:0] spd);
    double_ride = share;
    night       = night_mode;
    speed_sel   = spd;
    onride      = 1'b1;
    repeat (3) @(posedge clk);  // start fare loaded by then
    #1;
  endtask

  task automatic end_ride();
    onride = 1'b0;
    repeat (3) @(posedge clk);
    #1;
  endtask

  `include "taxi_meter_tests.svh"

endmodule

`default_nettype wire
